//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

  typedef logic [31:0] data_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_ADDI  = 6'h08,
    OP_ANDI  = 6'h0c,
    OP_ORI   = 6'h0d
  } opcode_t;

  // add sits at zero so the all-zero word is a harmless add into r0
  typedef enum logic [5:0] {
    FN_ADD = 6'h00,
    FN_SUB = 6'h02,
    FN_AND = 6'h04,
    FN_OR  = 6'h05,
    FN_SLL = 6'h08,
    FN_SLT = 6'h0a
  } funct_t;

  typedef struct packed {
    opcode_t  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    reg_idx_t shamt;
    funct_t   funct;
  } r_fields_t;

  typedef struct packed {
    opcode_t     opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] imm;
  } i_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_u;

  localparam instr_u NOP_WORD = '0;

  // destination register, zero when the word writes nothing
  function automatic reg_idx_t write_dest(instr_u w);
    reg_idx_t d;
    d = '0;
    case (w.r.opcode)
      OP_RTYPE: begin
        case (w.r.funct)
          FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLL: d = w.r.rd;
          default: d = '0;
        endcase
      end
      OP_ADDI, OP_ANDI, OP_ORI: d = w.i.rt;
      default: d = '0;
    endcase
    return d;
  endfunction

endpackage

`default_nettype wire

//--- src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4,
    ALU_SLL = 3'd5
  } alu_op_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    use_imm;
    logic    dst_is_rd;
    logic    reg_write;
  } ctrl_t;

  typedef struct packed {
    ctrl_t             ctrl;
    isa_pkg::reg_idx_t rs;
    isa_pkg::reg_idx_t rt;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t shamt;
    logic [15:0]       imm;
    isa_pkg::data_t    rs_data;
    isa_pkg::data_t    rt_data;
  } id_ex_t;

  // operand source in execute
  typedef enum logic [1:0] {
    FWD_RF  = 2'd0,
    FWD_WB0 = 2'd1,
    FWD_WB1 = 2'd2
  } fwd_sel_t;

  // one register write leaving the pipe
  typedef struct packed {
    logic              valid;
    isa_pkg::reg_idx_t dest;
    isa_pkg::data_t    data;
  } retire_t;

endpackage

`default_nettype wire

//--- src/issue_steer.sv
`default_nettype none

module issue_steer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pair_valid,
  input  isa_pkg::instr_u [1:0] pair_instr,
  output logic                  stall,
  output isa_pkg::instr_u [1:0] issue_instr
);

  isa_pkg::reg_idx_t     l0_dest;
  logic                  l1_reads_rt;
  logic                  dependent;
  logic                  split_q;
  isa_pkg::instr_u [1:0] issue_next;

  //////////////////////////////////////////////////////////////////////
  // lane 1 on lane 0 dependency
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    l0_dest     = isa_pkg::write_dest(pair_instr[0]);
    // rt is only a source for r-type
    l1_reads_rt = (pair_instr[1].r.opcode == isa_pkg::OP_RTYPE);
    dependent   = (l0_dest != '0) &&
                  ((pair_instr[1].r.rs == l0_dest) ||
                   (l1_reads_rt && (pair_instr[1].r.rt == l0_dest)));
  end

  // first half of a split pair holds the source
  assign stall = pair_valid && dependent && !split_q;

  always_comb begin
    issue_next = pair_instr;
    if (!pair_valid) begin
      issue_next[0] = isa_pkg::NOP_WORD;
      issue_next[1] = isa_pkg::NOP_WORD;
    end else if (split_q) begin
      // second half, older lane already gone
      issue_next[0] = isa_pkg::NOP_WORD;
    end else if (dependent) begin
      issue_next[1] = isa_pkg::NOP_WORD;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // intake register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      split_q     <= 1'b0;
      issue_instr <= {2{isa_pkg::NOP_WORD}};
    end else begin
      split_q     <= stall;
      issue_instr <= issue_next;
    end
  end

endmodule

`default_nettype wire

//--- src/decode_unit.sv
`default_nettype none

module decode_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  isa_pkg::instr_u   instr,
  output isa_pkg::reg_idx_t rs,
  output isa_pkg::reg_idx_t rt,
  input  isa_pkg::data_t    rs_data,
  input  isa_pkg::data_t    rt_data,
  output pipe_pkg::id_ex_t  id_ex
);

  pipe_pkg::ctrl_t  ctrl;
  pipe_pkg::id_ex_t id_ex_next;

  // rs and rt sit at the same place in both views
  assign rs = instr.r.rs;
  assign rt = instr.r.rt;

  //////////////////////////////////////////////////////////////////////
  // control word
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl           = '0;
    // unknown opcode or funct has no destination
    ctrl.reg_write = (isa_pkg::write_dest(instr) != '0);
    case (instr.r.opcode)
      isa_pkg::OP_RTYPE: begin
        ctrl.dst_is_rd = 1'b1;
        case (instr.r.funct)
          isa_pkg::FN_SUB: ctrl.alu_op = pipe_pkg::ALU_SUB;
          isa_pkg::FN_AND: ctrl.alu_op = pipe_pkg::ALU_AND;
          isa_pkg::FN_OR:  ctrl.alu_op = pipe_pkg::ALU_OR;
          isa_pkg::FN_SLT: ctrl.alu_op = pipe_pkg::ALU_SLT;
          isa_pkg::FN_SLL: ctrl.alu_op = pipe_pkg::ALU_SLL;
          default:         ctrl.alu_op = pipe_pkg::ALU_ADD;
        endcase
      end
      isa_pkg::OP_ADDI: begin
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = pipe_pkg::ALU_ADD;
      end
      isa_pkg::OP_ANDI: begin
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = pipe_pkg::ALU_AND;
      end
      isa_pkg::OP_ORI: begin
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = pipe_pkg::ALU_OR;
      end
      default: ctrl.alu_op = pipe_pkg::ALU_ADD;
    endcase
  end

  always_comb begin
    id_ex_next         = '0;
    id_ex_next.ctrl    = ctrl;
    id_ex_next.rs      = instr.r.rs;
    id_ex_next.rt      = instr.r.rt;
    id_ex_next.rs_data = rs_data;
    id_ex_next.rt_data = rt_data;
    if (instr.r.opcode == isa_pkg::OP_RTYPE) begin
      id_ex_next.rd    = instr.r.rd;
      id_ex_next.shamt = instr.r.shamt;
    end else begin
      id_ex_next.imm = instr.i.imm;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else begin
      id_ex <= id_ex_next;
    end
  end

endmodule

`default_nettype wire

//--- src/register_file.sv
`default_nettype none

module register_file (
  input  logic                    clk,
  input  logic                    rst_n,
  input  isa_pkg::reg_idx_t [3:0] rd_addr,
  output isa_pkg::data_t    [3:0] rd_data,
  input  pipe_pkg::retire_t [1:0] wr
);

  isa_pkg::data_t regs [32];

  // lane 0 first, lane 1 overrides on the same register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int w = 0; w < 2; w++) begin
        if (wr[w].valid && (wr[w].dest != '0)) begin
          regs[wr[w].dest] <= wr[w].data;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read ports with write-through
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < 4; p++) begin
      if (rd_addr[p] == '0) begin
        rd_data[p] = '0;
      end else if (wr[1].valid && (wr[1].dest == rd_addr[p])) begin
        rd_data[p] = wr[1].data;
      end else if (wr[0].valid && (wr[0].dest == rd_addr[p])) begin
        rd_data[p] = wr[0].data;
      end else begin
        rd_data[p] = regs[rd_addr[p]];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/execute_lane.sv
`default_nettype none

module execute_lane (
  input  logic                    clk,
  input  logic                    rst_n,
  input  pipe_pkg::id_ex_t        id_ex,
  input  pipe_pkg::retire_t [1:0] wb,
  output pipe_pkg::retire_t       result
);

  pipe_pkg::fwd_sel_t fwd_a;
  pipe_pkg::fwd_sel_t fwd_b;
  isa_pkg::data_t     op_a;
  isa_pkg::data_t     op_b;
  isa_pkg::data_t     alu_b;
  isa_pkg::data_t     alu_out;
  isa_pkg::reg_idx_t  dest;
  pipe_pkg::retire_t  result_next;

  // younger lane first, r0 never forwarded
  function automatic pipe_pkg::fwd_sel_t fwd_select(
    isa_pkg::reg_idx_t       src,
    pipe_pkg::retire_t [1:0] recs
  );
    pipe_pkg::fwd_sel_t sel;
    sel = pipe_pkg::FWD_RF;
    if (src != '0) begin
      if (recs[1].valid && (recs[1].dest == src)) begin
        sel = pipe_pkg::FWD_WB1;
      end else if (recs[0].valid && (recs[0].dest == src)) begin
        sel = pipe_pkg::FWD_WB0;
      end
    end
    return sel;
  endfunction

  function automatic isa_pkg::data_t fwd_mux(
    pipe_pkg::fwd_sel_t      sel,
    isa_pkg::data_t          rf_data,
    pipe_pkg::retire_t [1:0] recs
  );
    case (sel)
      pipe_pkg::FWD_WB0: return recs[0].data;
      pipe_pkg::FWD_WB1: return recs[1].data;
      default:           return rf_data;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // operands and alu
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fwd_a = fwd_select(id_ex.rs, wb);
    fwd_b = fwd_select(id_ex.rt, wb);
  end

  assign op_a  = fwd_mux(fwd_a, id_ex.rs_data, wb);
  assign op_b  = fwd_mux(fwd_b, id_ex.rt_data, wb);
  assign alu_b = id_ex.ctrl.use_imm ? {16'h0000, id_ex.imm} : op_b;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      pipe_pkg::ALU_ADD: alu_out = op_a + alu_b;
      pipe_pkg::ALU_SUB: alu_out = op_a - alu_b;
      pipe_pkg::ALU_AND: alu_out = op_a & alu_b;
      pipe_pkg::ALU_OR:  alu_out = op_a | alu_b;
      pipe_pkg::ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
      // shifts rt, never the immediate
      pipe_pkg::ALU_SLL: alu_out = alu_b << id_ex.shamt;
      default:           alu_out = '0;
    endcase
  end

  assign dest = id_ex.ctrl.dst_is_rd ? id_ex.rd : id_ex.rt;

  always_comb begin
    result_next.valid = id_ex.ctrl.reg_write && (dest != '0);
    result_next.dest  = dest;
    result_next.data  = alu_out;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result <= '0;
    end else begin
      result <= result_next;
    end
  end

endmodule

`default_nettype wire

//--- src/dual_issue_core.sv
`default_nettype none

module dual_issue_core (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         pair_valid,
  input  isa_pkg::instr_u [1:0]        pair_instr,
  output logic                         stall,
  output wire pipe_pkg::retire_t [1:0] retire
);

  wire isa_pkg::instr_u [1:0]   issue_instr;
  wire isa_pkg::reg_idx_t [3:0] rd_addr;
  wire isa_pkg::data_t [3:0]    rd_data;
  wire pipe_pkg::id_ex_t [1:0]  id_ex;

  //////////////////////////////////////////////////////////////////////
  // intake and steering
  //////////////////////////////////////////////////////////////////////

  issue_steer u_steer (
    .clk         (clk),
    .rst_n       (rst_n),
    .pair_valid  (pair_valid),
    .pair_instr  (pair_instr),
    .stall       (stall),
    .issue_instr (issue_instr)
  );

  // read ports 2g and 2g+1 belong to lane g
  register_file u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr      (retire)
  );

  //////////////////////////////////////////////////////////////////////
  // lanes
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < 2; g++) begin : g_lane
    decode_unit u_decode (
      .clk     (clk),
      .rst_n   (rst_n),
      .instr   (issue_instr[g]),
      .rs      (rd_addr[2*g]),
      .rt      (rd_addr[2*g+1]),
      .rs_data (rd_data[2*g]),
      .rt_data (rd_data[2*g+1]),
      .id_ex   (id_ex[g])
    );

    // both lanes see both writeback records
    execute_lane u_exec (
      .clk    (clk),
      .rst_n  (rst_n),
      .id_ex  (id_ex[g]),
      .wb     (retire),
      .result (retire[g])
    );
  end

endmodule

`default_nettype wire

//--- sim/tb_dual_issue_core.sv
`default_nettype none

module tb_dual_issue_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 10;
  localparam int N_TESTS      = 6;
  localparam int N_INDEP      = 200;
  localparam int N_SPLIT      = 60;
  localparam int N_FWD        = 200;
  localparam int N_SAME       = 40;
  localparam int N_GAP        = 100;
  localparam int TOTAL_PAIRS  = N_INDEP + N_SPLIT + N_FWD + 2 * N_SAME + N_GAP;
  localparam int WATCHDOG_CYCLES = TOTAL_PAIRS * 2 + 4 * N_TESTS + 20;

  logic                         clk;
  logic                         rst_n;
  logic                         pair_valid;
  isa_pkg::instr_u [1:0]        pair_instr;
  wire                          stall;
  wire pipe_pkg::retire_t [1:0] retire;

  int                seed = 50;
  int                errors;
  int                n_checks;
  int                test_err_base;
  string             cur_test;
  isa_pkg::data_t    model_regs [32];
  pipe_pkg::retire_t expected_q [$];

  dual_issue_core dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .pair_valid (pair_valid),
    .pair_instr (pair_instr),
    .stall      (stall),
    .retire     (retire)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired in test %s, the pipeline stopped making progress", cur_test);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic check(input string what, input logic [63:0] expected,
                       input logic [63:0] actual);
    n_checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic isa_pkg::reg_idx_t model_dest(input isa_pkg::instr_u w);
    case (w.r.opcode)
      isa_pkg::OP_RTYPE: begin
        case (w.r.funct)
          isa_pkg::FN_ADD, isa_pkg::FN_SUB, isa_pkg::FN_AND,
          isa_pkg::FN_OR, isa_pkg::FN_SLT, isa_pkg::FN_SLL: return w.r.rd;
          default: return '0;
        endcase
      end
      isa_pkg::OP_ADDI, isa_pkg::OP_ANDI, isa_pkg::OP_ORI: return w.i.rt;
      default: return '0;
    endcase
  endfunction

  // lane 1 reads rs always, rt only as r-type
  function automatic bit is_dependent(input isa_pkg::instr_u w0, input isa_pkg::instr_u w1);
    isa_pkg::reg_idx_t d;
    d = model_dest(w0);
    if (d == '0) return 1'b0;
    if (w1.r.rs == d) return 1'b1;
    return (w1.r.opcode == isa_pkg::OP_RTYPE) && (w1.r.rt == d);
  endfunction

  function automatic void model_exec(input isa_pkg::instr_u w);
    isa_pkg::data_t    a;
    isa_pkg::data_t    b;
    isa_pkg::data_t    imm;
    isa_pkg::data_t    res;
    isa_pkg::reg_idx_t d;
    pipe_pkg::retire_t rec;
    a   = model_regs[w.r.rs];
    b   = model_regs[w.r.rt];
    imm = {16'h0000, w.i.imm};
    d   = model_dest(w);
    res = '0;
    case (w.r.opcode)
      isa_pkg::OP_RTYPE: begin
        case (w.r.funct)
          isa_pkg::FN_ADD: res = a + b;
          isa_pkg::FN_SUB: res = a - b;
          isa_pkg::FN_AND: res = a & b;
          isa_pkg::FN_OR:  res = a | b;
          isa_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          isa_pkg::FN_SLL: res = b << w.r.shamt;
          default:         res = '0;
        endcase
      end
      isa_pkg::OP_ADDI: res = a + imm;
      isa_pkg::OP_ANDI: res = a & imm;
      isa_pkg::OP_ORI:  res = a | imm;
      default:          res = '0;
    endcase
    if (d != '0) begin
      model_regs[d] = res;
      rec.valid = 1'b1;
      rec.dest  = d;
      rec.data  = res;
      expected_q.push_back(rec);
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic int rnd_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // kinds 9 and 10 are an undefined opcode and an undefined funct
  function automatic isa_pkg::instr_u gen_instr(input int nregs, input bit allow_bad);
    isa_pkg::instr_u w;
    int              kind;
    kind   = rnd_below(allow_bad ? 11 : 9);
    w      = $random(seed);
    w.r.rs = isa_pkg::reg_idx_t'(rnd_below(nregs));
    w.r.rt = isa_pkg::reg_idx_t'(rnd_below(nregs));
    if (kind < 6 || kind == 10) begin
      w.r.opcode = isa_pkg::OP_RTYPE;
      w.r.rd     = isa_pkg::reg_idx_t'(rnd_below(nregs));
    end
    case (kind)
      0: w.r.funct = isa_pkg::FN_ADD;
      1: w.r.funct = isa_pkg::FN_SUB;
      2: w.r.funct = isa_pkg::FN_AND;
      3: w.r.funct = isa_pkg::FN_OR;
      4: w.r.funct = isa_pkg::FN_SLT;
      5: w.r.funct = isa_pkg::FN_SLL;
      6: w.i.opcode = isa_pkg::OP_ADDI;
      7: w.i.opcode = isa_pkg::OP_ANDI;
      8: w.i.opcode = isa_pkg::OP_ORI;
      9: w[31:26] = 6'(32 + rnd_below(32));
      default: w[5:0] = 6'(48 + rnd_below(16));
    endcase
    return w;
  endfunction

  function automatic isa_pkg::instr_u set_dest(input isa_pkg::instr_u w,
                                               input isa_pkg::reg_idx_t d);
    if (w.r.opcode == isa_pkg::OP_RTYPE) w.r.rd = d;
    else w.i.rt = d;
    return w;
  endfunction

  // holds the pair until taken, a dependent pair stalls once
  task automatic issue_pair(input isa_pkg::instr_u w0, input isa_pkg::instr_u w1);
    int   stalls;
    int   exp_stalls;
    logic s;
    stalls     = 0;
    exp_stalls = is_dependent(w0, w1) ? 1 : 0;
    model_exec(w0);
    model_exec(w1);
    pair_valid    = 1'b1;
    pair_instr[0] = w0;
    pair_instr[1] = w1;
    do begin
      @(negedge clk);
      s = stall;
      @(posedge clk);
      #DRIVE_DELAY;
      if (s === 1'b1) stalls++;
    end while (s === 1'b1);
    check({cur_test, " stall cycles"}, exp_stalls, stalls);
    pair_valid = 1'b0;
    pair_instr = {isa_pkg::NOP_WORD, isa_pkg::NOP_WORD};
  endtask

  task automatic idle(input int n);
    pair_valid = 1'b0;
    pair_instr = {isa_pkg::NOP_WORD, isa_pkg::NOP_WORD};
    repeat (n) begin
      @(negedge clk);
      check({cur_test, " idle stall"}, 0, stall);
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = errors;
  endtask

  task automatic end_test();
    idle(4);
    if (expected_q.size() != 0) begin
      $display("%s: %0d expected retirements are missing", cur_test, expected_q.size());
      errors++;
      expected_q.delete();
    end
    $display("test %s finished with %0d errors", cur_test, errors - test_err_base);
  endtask

  //////////////////////////////////////////////////////////////////////
  // retire monitor
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : retire_monitor
    pipe_pkg::retire_t rec;
    if (rst_n) begin
      for (int l = 0; l < 2; l++) begin
        if (retire[l].valid === 1'b1) begin
          if (retire[l].dest == '0) begin
            errors++;
            $display("%s: lane %0d retired a write to r0", cur_test, l);
          end else if (expected_q.size() == 0) begin
            errors++;
            $display("%s: lane %0d retired r%0d with no write expected",
                     cur_test, l, retire[l].dest);
          end else begin
            rec = expected_q.pop_front();
            check({cur_test, " retire dest"}, rec.dest, retire[l].dest);
            check({cur_test, " retire data"}, rec.data, retire[l].data);
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    isa_pkg::instr_u   w0;
    isa_pkg::instr_u   w1;
    isa_pkg::reg_idx_t d;
    errors     = 0;
    n_checks   = 0;
    rst_n      = 1'b0;
    pair_valid = 1'b0;
    pair_instr = {isa_pkg::NOP_WORD, isa_pkg::NOP_WORD};
    for (int r = 0; r < 32; r++) model_regs[r] = '0;

    start_test("reset");
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check({cur_test, " stall"}, 0, stall);
      check({cur_test, " retire valid"}, 0, {retire[1].valid, retire[0].valid});
    end
    @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    end_test();

    start_test("independent");
    for (int k = 0; k < N_INDEP; k++) begin
      w0 = gen_instr(32, 1'b0);
      w1 = gen_instr(32, 1'b0);
      while (is_dependent(w0, w1)) w1 = gen_instr(32, 1'b0);
      issue_pair(w0, w1);
    end
    end_test();

    start_test("split");
    for (int k = 0; k < N_SPLIT; k++) begin
      w0 = gen_instr(8, 1'b0);
      while (model_dest(w0) == '0) w0 = gen_instr(8, 1'b0);
      w1 = gen_instr(8, 1'b0);
      if (w1.r.opcode == isa_pkg::OP_RTYPE && rnd_below(2) == 1) w1.r.rt = model_dest(w0);
      else w1.r.rs = model_dest(w0);
      issue_pair(w0, w1);
    end
    end_test();

    start_test("forwarding");
    for (int k = 0; k < N_FWD; k++) begin
      issue_pair(gen_instr(4, 1'b0), gen_instr(4, 1'b0));
    end
    end_test();

    // both lanes to one register, then a reader of it and a reader of r0
    start_test("same_dest");
    for (int k = 0; k < N_SAME; k++) begin
      d  = isa_pkg::reg_idx_t'(rnd_below(4));
      w0 = set_dest(gen_instr(8, 1'b0), d);
      w1 = set_dest(gen_instr(8, 1'b0), d);
      issue_pair(w0, w1);
      w0      = gen_instr(8, 1'b0);
      w0.r.rs = d;
      w1      = gen_instr(8, 1'b0);
      w1.r.rs = '0;
      w1      = set_dest(w1, isa_pkg::reg_idx_t'(1 + rnd_below(7)));
      issue_pair(w0, w1);
    end
    end_test();

    start_test("gaps");
    for (int k = 0; k < N_GAP; k++) begin
      if (rnd_below(4) == 0) idle(1 + rnd_below(2));
      issue_pair(gen_instr(8, 1'b1), gen_instr(8, 1'b1));
    end
    end_test();

    $display("tests %0d, checks %0d, errors %0d", N_TESTS, n_checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dual_issue_core.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/issue_steer.sv
src/decode_unit.sv
src/register_file.sv
src/execute_lane.sv
src/dual_issue_core.sv
sim/tb_dual_issue_core.sv

//--- Bender.yml
package:
  name: dual_issue_core

sources:
  - src/isa_pkg.sv
  - src/pipe_pkg.sv
  - src/issue_steer.sv
  - src/decode_unit.sv
  - src/register_file.sv
  - src/execute_lane.sv
  - src/dual_issue_core.sv
  - target: test
    files:
      - sim/tb_dual_issue_core.sv
